// ==== design/cache_macros.svh ====
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// Bus widths.
`define ADDR_W      32
`define DATA_W      32
`define STRB_W      4

// Cache geometry of 4 sets by 4 ways with 16 words per line.
`define NUM_SETS    4
`define NUM_WAYS    4
`define LINE_WORDS  16

// Address field widths.
`define TAG_W       24
`define SET_W       2
`define WORD_W      4
`define WAY_W       2

`endif

// ==== design/cache_pkg.sv ====
`include "cache_macros.svh"

package cache_pkg;

    // A byte address seen raw or split into its cache fields.
    typedef struct packed {
        logic [`TAG_W-1:0]  tag;
        logic [`SET_W-1:0]  set;
        logic [`WORD_W-1:0] word;
        logic [1:0]         byte_off;
    } cache_addr_fields_t;

    typedef union packed {
        logic [`ADDR_W-1:0] raw;
        cache_addr_fields_t fields;
    } cache_addr_t;

    // Request controller states.
    typedef enum logic [1:0] {
        st_idle,
        st_lookup,
        st_miss_wait,
        st_respond
    } ctrl_state_t;

endpackage

// ==== design/cache_ifs.sv ====
`include "cache_macros.svh"

// Lookup and store merge between the controller and the tag and data store.
interface store_if import cache_pkg::*; ();
    cache_addr_t        lookup_addr;
    logic               write_en;
    logic [`STRB_W-1:0] write_strb;
    logic [`DATA_W-1:0] write_data;
    logic               hit;
    logic [`DATA_W-1:0] read_data;

    modport ctrl (output lookup_addr, write_en, write_strb, write_data,
                  input  hit, read_data);

    modport storage (input  lookup_addr, write_en, write_strb, write_data,
                     output hit, read_data);
endinterface

// Line transfers between controller, store and AXI engine.
interface line_if ();
    logic               start;
    logic               victim_dirty;
    logic [`ADDR_W-1:0] victim_addr;
    logic [`ADDR_W-1:0] fill_addr;
    logic [`DATA_W-1:0] line_rdata;
    logic [`WORD_W-1:0] word_idx;
    logic               fill_we;
    logic [`DATA_W-1:0] fill_data;
    logic               fill_done;

    modport ctrl (output start, input fill_done);

    modport storage (input  word_idx, fill_we, fill_data, fill_done,
                     output victim_dirty, victim_addr, fill_addr, line_rdata);

    modport engine (input  start, victim_dirty, victim_addr, fill_addr, line_rdata,
                    output word_idx, fill_we, fill_data, fill_done);
endinterface

// ==== design/cache_req_ctrl.sv ====
`include "cache_macros.svh"

module cache_req_ctrl import cache_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               req_valid,
    input  logic               req_write,
    input  cache_addr_t        req_addr,
    input  logic [`DATA_W-1:0] req_wdata,
    input  logic [`STRB_W-1:0] req_strb,
    output logic               req_ready,
    output logic               resp_valid,
    output logic [`DATA_W-1:0] resp_rdata,
    store_if.ctrl              store,
    line_if.ctrl               line
);

    ctrl_state_t        state_q;
    ctrl_state_t        state_d;
    logic               ready_q;
    logic               accept;
    cache_addr_t        addr_q;
    logic               write_q;
    logic [`DATA_W-1:0] wdata_q;
    logic [`STRB_W-1:0] strb_q;
    logic [`DATA_W-1:0] rdata_q;

    assign accept = req_valid && ready_q;

    // ##################################################
    // Request FSM.
    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle: begin
                if (accept) begin
                    state_d = st_lookup;
                end
            end
            st_lookup: begin
                state_d = store.hit ? st_respond : st_miss_wait;
            end
            st_miss_wait: begin
                // Line is installed so the next lookup hits.
                if (line.fill_done) begin
                    state_d = st_lookup;
                end
            end
            st_respond: begin
                state_d = st_idle;
            end
            default: begin
                state_d = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= st_idle;
            ready_q <= 1'b0;
        end else begin
            state_q <= state_d;
            ready_q <= (state_d == st_idle);
        end
    end

    // Held request and read result.
    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q  <= req_addr;
            write_q <= req_write;
            wdata_q <= req_wdata;
            strb_q  <= req_strb;
        end
        if (state_q == st_lookup && store.hit && !write_q) begin
            rdata_q <= store.read_data;
        end
    end

    // ##################################################
    assign store.lookup_addr = addr_q;
    assign store.write_en    = (state_q == st_lookup) && store.hit && write_q;
    assign store.write_strb  = strb_q;
    assign store.write_data  = wdata_q;

    assign line.start = (state_q == st_lookup) && !store.hit;

    assign req_ready  = ready_q;
    assign resp_valid = (state_q == st_respond);
    assign resp_rdata = rdata_q;

endmodule

// ==== design/cache_store.sv ====
`include "cache_macros.svh"

module cache_store import cache_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    store_if.storage store,
    line_if.storage  line
);

    localparam int LINE_OFF_W = `WORD_W + 2;

    logic [`TAG_W-1:0]    tag_q    [`NUM_SETS][`NUM_WAYS];
    logic [`DATA_W-1:0]   data_q   [`NUM_SETS][`NUM_WAYS][`LINE_WORDS];
    logic [`NUM_WAYS-1:0] valid_q  [`NUM_SETS];
    logic [`NUM_WAYS-1:0] dirty_q  [`NUM_SETS];
    logic [`WAY_W-1:0]    fifo_ptr_q [`NUM_SETS];

    cache_addr_t          lookup;
    logic [`SET_W-1:0]    set_idx;
    logic [`WORD_W-1:0]   word_sel;
    logic [`NUM_WAYS-1:0] hit_vec;
    logic [`WAY_W-1:0]    hit_way;
    logic                 hit;
    logic [`WAY_W-1:0]    victim_way;

    assign lookup     = store.lookup_addr;
    assign set_idx    = lookup.fields.set;
    assign word_sel   = lookup.fields.word;
    assign victim_way = fifo_ptr_q[set_idx];

    // ##################################################
    // Tag compare across the ways of the set.
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < `NUM_WAYS; w++) begin
            hit_vec[w] = valid_q[set_idx][w] && (tag_q[set_idx][w] == lookup.fields.tag);
            if (hit_vec[w]) begin
                hit_way = w[`WAY_W-1:0];
            end
        end
    end

    assign hit             = |hit_vec;
    assign store.hit       = hit;
    assign store.read_data = data_q[set_idx][hit_way][word_sel];

    // Victim is whatever sits at the set's FIFO pointer.
    assign line.victim_dirty = valid_q[set_idx][victim_way] && dirty_q[set_idx][victim_way];
    assign line.victim_addr  = {tag_q[set_idx][victim_way], set_idx, {LINE_OFF_W{1'b0}}};
    assign line.fill_addr    = {lookup.raw[`ADDR_W-1:LINE_OFF_W], {LINE_OFF_W{1'b0}}};
    assign line.line_rdata   = data_q[set_idx][victim_way][line.word_idx];

    // ##################################################
    // Line state and replacement pointers.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < `NUM_SETS; s++) begin
                valid_q[s]    <= '0;
                dirty_q[s]    <= '0;
                fifo_ptr_q[s] <= '0;
            end
        end else begin
            if (store.write_en && hit) begin
                dirty_q[set_idx][hit_way] <= 1'b1;
            end
            if (line.fill_done) begin
                valid_q[set_idx][victim_way] <= 1'b1;
                dirty_q[set_idx][victim_way] <= 1'b0;
                fifo_ptr_q[set_idx]          <= victim_way + `WAY_W'(1);
            end
        end
    end

    // Tags and line data.
    always_ff @(posedge clk) begin
        if (store.write_en && hit) begin
            for (int b = 0; b < `STRB_W; b++) begin
                if (store.write_strb[b]) begin
                    data_q[set_idx][hit_way][word_sel][8*b +: 8] <= store.write_data[8*b +: 8];
                end
            end
        end
        if (line.fill_we) begin
            data_q[set_idx][victim_way][line.word_idx] <= line.fill_data;
        end
        if (line.fill_done) begin
            tag_q[set_idx][victim_way] <= lookup.fields.tag;
        end
    end

endmodule

// ==== design/axi_line_master.sv ====
`include "cache_macros.svh"

module axi_line_master (
    input  logic               clk,
    input  logic               rst_n,
    line_if.engine             line,
    output logic [`ADDR_W-1:0] m_araddr,
    output logic               m_arvalid,
    input  logic               m_arready,
    input  logic [`DATA_W-1:0] m_rdata,
    input  logic               m_rlast,
    input  logic               m_rvalid,
    output logic               m_rready,
    output logic [`ADDR_W-1:0] m_awaddr,
    output logic               m_awvalid,
    input  logic               m_awready,
    output logic [`DATA_W-1:0] m_wdata,
    output logic               m_wlast,
    output logic               m_wvalid,
    input  logic               m_wready,
    input  logic               m_bvalid,
    output logic               m_bready
);

    typedef enum logic [2:0] {
        eng_idle,
        eng_aw,
        eng_w,
        eng_b,
        eng_ar,
        eng_r,
        eng_done
    } eng_state_t;

    eng_state_t         state_q;
    logic [`WORD_W-1:0] word_idx_q;
    logic [`ADDR_W-1:0] aw_addr_q;
    logic [`ADDR_W-1:0] ar_addr_q;

    //##################################################
    // Write-back then refill sequencing.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= eng_idle;
            word_idx_q <= '0;
        end else begin
            case (state_q)
                eng_idle: begin
                    word_idx_q <= '0;
                    if (line.start) begin
                        state_q <= line.victim_dirty ? eng_aw : eng_ar;
                    end
                end
                eng_aw: if (m_awready) state_q <= eng_w;
                eng_w: begin
                    if (m_wready) begin
                        word_idx_q <= word_idx_q + 1'b1;
                        if (m_wlast) begin
                            state_q <= eng_b;
                        end
                    end
                end
                eng_b: if (m_bvalid) state_q <= eng_ar;
                eng_ar: if (m_arready) state_q <= eng_r;
                eng_r: begin
                    if (m_rvalid) begin
                        word_idx_q <= word_idx_q + 1'b1;
                        if (m_rlast) begin
                            state_q <= eng_done;
                        end
                    end
                end
                default: state_q <= eng_idle;
            endcase
        end
    end

    // Burst addresses are taken once at start.
    always_ff @(posedge clk) begin
        if (state_q == eng_idle && line.start) begin
            aw_addr_q <= line.victim_addr;
            ar_addr_q <= line.fill_addr;
        end
    end

    //##################################################
    assign m_awaddr  = aw_addr_q;
    assign m_awvalid = (state_q == eng_aw);
    assign m_wvalid  = (state_q == eng_w);
    assign m_wdata   = line.line_rdata;
    assign m_wlast   = (state_q == eng_w) && (word_idx_q == `WORD_W'(`LINE_WORDS - 1));
    assign m_bready  = (state_q == eng_b);
    assign m_araddr  = ar_addr_q;
    assign m_arvalid = (state_q == eng_ar);
    assign m_rready  = (state_q == eng_r);

    assign line.word_idx  = word_idx_q;
    assign line.fill_we   = (state_q == eng_r) && m_rvalid;
    assign line.fill_data = m_rdata;
    assign line.fill_done = (state_q == eng_done);

endmodule

// ==== design/dcache_top.sv ====
`include "cache_macros.svh"

module dcache_top (
    input  logic               clk,
    input  logic               rst_n,
    // Processor load/store port.
    input  logic               req_valid,
    output logic               req_ready,
    input  logic               req_write,
    input  logic [`ADDR_W-1:0] req_addr,
    input  logic [`DATA_W-1:0] req_wdata,
    input  logic [`STRB_W-1:0] req_strb,
    output logic               resp_valid,
    output logic [`DATA_W-1:0] resp_rdata,
    // AXI memory port.
    output logic [`ADDR_W-1:0] m_araddr,
    output logic               m_arvalid,
    input  logic               m_arready,
    input  logic [`DATA_W-1:0] m_rdata,
    input  logic               m_rlast,
    input  logic               m_rvalid,
    output logic               m_rready,
    output logic [`ADDR_W-1:0] m_awaddr,
    output logic               m_awvalid,
    input  logic               m_awready,
    output logic [`DATA_W-1:0] m_wdata,
    output logic               m_wlast,
    output logic               m_wvalid,
    input  logic               m_wready,
    input  logic               m_bvalid,
    output logic               m_bready
);

    store_if store_bus ();
    line_if  line_bus ();

    cache_req_ctrl i_req_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req_write  (req_write),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .req_strb   (req_strb),
        .req_ready  (req_ready),
        .resp_valid (resp_valid),
        .resp_rdata (resp_rdata),
        .store      (store_bus),
        .line       (line_bus)
    );

    cache_store i_store (
        .clk   (clk),
        .rst_n (rst_n),
        .store (store_bus),
        .line  (line_bus)
    );

    axi_line_master i_axi_master (
        .clk       (clk),
        .rst_n     (rst_n),
        .line      (line_bus),
        .m_araddr  (m_araddr),
        .m_arvalid (m_arvalid),
        .m_arready (m_arready),
        .m_rdata   (m_rdata),
        .m_rlast   (m_rlast),
        .m_rvalid  (m_rvalid),
        .m_rready  (m_rready),
        .m_awaddr  (m_awaddr),
        .m_awvalid (m_awvalid),
        .m_awready (m_awready),
        .m_wdata   (m_wdata),
        .m_wlast   (m_wlast),
        .m_wvalid  (m_wvalid),
        .m_wready  (m_wready),
        .m_bvalid  (m_bvalid),
        .m_bready  (m_bready)
    );

endmodule

// ==== dv/axi_mem_model.sv ====
`include "cache_macros.svh"

module axi_mem_model #(
    parameter logic [31:0] SEED      = 32'h0000_0001,
    parameter int          DRIVE_DLY = 10
) (
    input  logic               clk,
    input  logic               rst_n,
    // Read address and data channels.
    input  logic [`ADDR_W-1:0] m_araddr,
    input  logic               m_arvalid,
    output logic               m_arready,
    output logic [`DATA_W-1:0] m_rdata,
    output logic               m_rlast,
    output logic               m_rvalid,
    input  logic               m_rready,
    // Write address, data and response channels.
    input  logic [`ADDR_W-1:0] m_awaddr,
    input  logic               m_awvalid,
    output logic               m_awready,
    input  logic [`DATA_W-1:0] m_wdata,
    input  logic               m_wlast,
    input  logic               m_wvalid,
    output logic               m_wready,
    output logic               m_bvalid,
    input  logic               m_bready,
    // Write bursts seen so far.
    output int                 aw_count,
    output logic [`ADDR_W-1:0] aw_last_addr
);

    localparam logic [31:0] PRELOAD_KEY = 32'hc0de_0000;

    logic [`DATA_W-1:0] mem [4096];
    logic [31:0]        lfsr;
    logic [11:0]        aw_idx;
    logic [11:0]        ar_idx;
    logic [4:0]         r_left;
    logic               b_pend;

    // Fibonacci LFSR with taps 32, 22, 2 and 1.
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bit(output logic b);
        lfsr = lfsr_step(lfsr);
        b    = lfsr[0];
    endtask

    initial begin
        logic r_fire;
        logic b_fire;
        logic in_reset;
        lfsr = SEED;
        for (int i = 0; i < 4096; i++) begin
            mem[i] = (32'(i) << 2) ^ PRELOAD_KEY;
        end
        {m_arready, m_rvalid, m_rlast, m_awready, m_wready, m_bvalid} = '0;
        m_rdata      = '0;
        aw_count     = 0;
        aw_last_addr = '0;
        aw_idx       = '0;
        ar_idx       = '0;
        r_left       = '0;
        b_pend       = 1'b0;
        forever begin
            // Handshakes and reset use the values seen at the clock edge.
            @(posedge clk);
            in_reset = !rst_n;
            r_fire   = m_rvalid && m_rready;
            b_fire   = m_bvalid && m_bready;
            if (m_awvalid && m_awready) begin
                aw_idx       = m_awaddr[13:2];
                aw_last_addr = m_awaddr;
                aw_count++;
            end
            if (m_wvalid && m_wready) begin
                mem[aw_idx] = m_wdata;
                aw_idx      = aw_idx + 12'd1;
                b_pend      = b_pend || m_wlast;
            end
            if (m_arvalid && m_arready) begin
                ar_idx = m_araddr[13:2];
                r_left = 5'd16;
            end
            if (r_fire) begin
                ar_idx = ar_idx + 12'd1;
                r_left = r_left - 5'd1;
            end

            // ##################################################
            #DRIVE_DLY;
            if (in_reset) begin
                {m_arready, m_rvalid, m_rlast, m_awready, m_wready, m_bvalid} = '0;
                r_left = '0;
                b_pend = 1'b0;
            end else begin
                draw_bit(m_awready);
                draw_bit(m_wready);
                draw_bit(m_arready);
                // A valid stays up until its beat is taken.
                if (b_fire) begin
                    m_bvalid = 1'b0;
                end
                if (b_pend && !m_bvalid) begin
                    draw_bit(m_bvalid);
                    b_pend = !m_bvalid;
                end
                if (r_fire) begin
                    m_rvalid = 1'b0;
                end
                if (r_left != 5'd0 && !m_rvalid) begin
                    draw_bit(m_rvalid);
                    m_rdata = mem[ar_idx];
                    m_rlast = (r_left == 5'd1);
                end
            end
        end
    end

endmodule

// ==== dv/tb_dcache.sv ====
`include "cache_macros.svh"

module tb_dcache;

    localparam int          CLK_PERIOD       = 100;
    localparam int          DRIVE_DLY        = 10;
    localparam int          RESET_CYCLES     = 16;
    localparam int          CYCLES_PER_ENTRY = 400;
    localparam logic [31:0] LFSR_SEED        = 32'hdd2f_8fac;
    localparam logic [31:0] PRELOAD_KEY      = 32'hc0de_0000;

    logic               clk;
    logic               rst_n;
    logic               req_valid, req_ready, req_write;
    logic [`ADDR_W-1:0] req_addr;
    logic [`DATA_W-1:0] req_wdata;
    logic [`STRB_W-1:0] req_strb;
    logic               resp_valid;
    logic [`DATA_W-1:0] resp_rdata;
    logic [`ADDR_W-1:0] m_araddr, m_awaddr;
    logic [`DATA_W-1:0] m_rdata, m_wdata;
    logic               m_arvalid, m_arready, m_rvalid, m_rready, m_rlast;
    logic               m_awvalid, m_awready, m_wvalid, m_wready, m_wlast;
    logic               m_bvalid, m_bready;
    int                 aw_count;
    logic [`ADDR_W-1:0] aw_last_addr;
    int                 cycle_count;
    int                 timeout_cycles;

    // Stimulus table with one request per entry.
    string              tab_name[$];
    logic               tab_write[$];
    logic [`ADDR_W-1:0] tab_addr[$];
    logic [`STRB_W-1:0] tab_strb[$];
    logic [`DATA_W-1:0] tab_wdata[$];
    logic [`DATA_W-1:0] tab_exp[$];
    int                 tab_lat[$];
    int                 tab_bursts[$];

    dcache_top i_dut (.*);

    axi_mem_model #(.SEED(LFSR_SEED), .DRIVE_DLY(DRIVE_DLY)) i_mem (.*);

    // Memory content before any write-back.
    function automatic logic [31:0] preload_word(input logic [31:0] addr);
        return addr ^ PRELOAD_KEY;
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  strb);
        logic [31:0] mask;
        mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        return (old_word & ~mask) | (new_word & mask);
    endfunction

    task automatic check_value(input string test, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERROR %s: expected 0x%08h, actual 0x%08h", test, expected, actual);
            $display("=== FAIL ===");
            $fatal(1);
        end
    endtask

    task automatic add_entry(input string name, input logic write,
                             input logic [31:0] addr, input logic [3:0] strb,
                             input logic [31:0] wdata, input logic [31:0] exp_data,
                             input int lat, input int bursts);
        tab_name.push_back(name);
        tab_write.push_back(write);
        tab_addr.push_back(addr);
        tab_strb.push_back(strb);
        tab_wdata.push_back(wdata);
        tab_exp.push_back(exp_data);
        tab_lat.push_back(lat);
        tab_bursts.push_back(bursts);
    endtask

    // ##################################################
    // One request from the handshake to its response.
    task run_entry(input int i);
        int lat;
        req_valid = 1'b1;
        req_write = tab_write[i];
        req_addr  = tab_addr[i];
        req_wdata = tab_wdata[i];
        req_strb  = tab_strb[i];
        while (!req_ready) begin
            @(posedge clk);
            #DRIVE_DLY;
        end
        // Accepted on this edge.
        @(posedge clk);
        #DRIVE_DLY;
        req_valid = 1'b0;
        lat = 1;
        while (!resp_valid) begin
            @(posedge clk);
            #DRIVE_DLY;
            lat++;
        end
        if (!tab_write[i]) begin
            check_value({tab_name[i], " data"}, tab_exp[i], resp_rdata);
        end
        if (tab_lat[i] != 0) begin
            check_value({tab_name[i], " latency"}, tab_lat[i], lat);
        end
        check_value({tab_name[i], " write bursts"}, tab_bursts[i], aw_count);
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        cycle_count = 0;
        // The table is filled at time zero, before the first edge.
        @(posedge clk);
        timeout_cycles = RESET_CYCLES + tab_name.size() * CYCLES_PER_ENTRY;
        while (cycle_count < timeout_cycles) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("The run did not finish within %0d clock cycles.", timeout_cycles);
        $display("=== FAIL ===");
        $fatal(1);
    end

    // ##################################################
    initial begin
        logic [31:0] merged_word;
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr  = '0;
        req_wdata = '0;
        req_strb  = '0;
        merged_word = merge_bytes(preload_word(32'h004), 32'h1122_3344, 4'b0101);

        // name, write, address, strobe, write data, read data, latency, write bursts
        add_entry("read_cold", 1'b0, 32'h004, 4'h0, 32'h0, preload_word(32'h004), 0, 0);
        add_entry("read_hit", 1'b0, 32'h008, 4'h0, 32'h0, preload_word(32'h008), 2, 0);
        add_entry("write_strobe", 1'b1, 32'h004, 4'b0101, 32'h1122_3344, 32'h0, 2, 0);
        add_entry("read_merged", 1'b0, 32'h004, 4'h0, 32'h0, merged_word, 2, 0);
        add_entry("write_alloc", 1'b1, 32'h1040, 4'hf, 32'ha5a5_5a5a, 32'h0, 0, 0);
        add_entry("read_alloc", 1'b0, 32'h1040, 4'h0, 32'h0, 32'ha5a5_5a5a, 2, 0);
        add_entry("fill_way1", 1'b0, 32'h104, 4'h0, 32'h0, preload_word(32'h104), 0, 0);
        add_entry("fill_way2", 1'b0, 32'h208, 4'h0, 32'h0, preload_word(32'h208), 0, 0);
        add_entry("fill_way3", 1'b0, 32'h30c, 4'h0, 32'h0, preload_word(32'h30c), 0, 0);
        add_entry("evict_dirty", 1'b0, 32'h410, 4'h0, 32'h0, preload_word(32'h410), 0, 1);
        add_entry("read_written_back", 1'b0, 32'h004, 4'h0, 32'h0, merged_word, 0, 1);
        add_entry("read_clean_word", 1'b0, 32'h03c, 4'h0, 32'h0, preload_word(32'h03c), 2, 1);

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;
        check_value("reset_outputs", 32'h0,
                    {25'h0, req_ready, resp_valid, m_arvalid, m_awvalid, m_wvalid,
                     m_rready, m_bready});

        for (int i = 0; i < tab_name.size(); i++) begin
            run_entry(i);
        end
        // The dirty line at 0x000 is the only one written back.
        check_value("write_burst_addr", 32'h0, aw_last_addr);

        $display("=== PASS ===");
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+design
design/cache_pkg.sv
design/cache_ifs.sv
design/cache_req_ctrl.sv
design/cache_store.sv
design/axi_line_master.sv
design/dcache_top.sv
dv/axi_mem_model.sv
dv/tb_dcache.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the data cache testbench with Verilator.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary -Wno-fatal --top-module tb_dcache -f flist.f -Mdir obj_dir; then
    echo "Verilator build failed."
    exit 1
fi

if ! ./obj_dir/Vtb_dcache; then
    echo "Simulation failed."
    exit 1
fi

echo "Simulation finished."
exit 0
